/* flight_rate_ctrl.f */
design/flight_rate_pkg.sv
design/axis_rate_pid.sv
design/gain_bus_arbiter.sv
design/pid_gain_regs.sv
design/quad_motor_mixer.sv
design/flight_rate_ctrl.sv
dv/flight_rate_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the rate control testbench with Verilator
# exit status is zero only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_LOG=build.log

rm -f "$LOG" "$BUILD_LOG"

verilator --binary -Wno-fatal --top-module flight_rate_ctrl_tb \
	-f flight_rate_ctrl.f -o flight_rate_ctrl_sim > "$BUILD_LOG" 2>&1 \
	|| { cat "$BUILD_LOG"; echo "build failed"; exit 1; }

./obj_dir/flight_rate_ctrl_sim > "$LOG" 2>&1 \
	; cat "$LOG"

grep -qF '*** PASSED ***' "$LOG" \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see $LOG"; exit 1; }

/* dv/flight_rate_ctrl_tb.sv */
// flight rate control testbench
`timescale 1ns/1ps

module flight_rate_ctrl_tb import flight_rate_pkg::*; ();

	// per tick budget plus host transfers with their arbitration wait
	localparam int TICK_CYCLES = 40;
	localparam int MAX_TICKS = 60;
	localparam int HOST_OPS = 120;
	localparam int HOST_OP_CYCLES = 8;
	localparam int TIMEOUT_CYCLES = MAX_TICKS * TICK_CYCLES + HOST_OPS * HOST_OP_CYCLES;

	logic us_clk;
	logic resetn;
	logic start;
	axis_sense_t sense [NUM_AXES];
	logic [MOTOR_BITS-1:0] thrust;
	wb_req_t host_req;
	wb_rsp_t host_rsp;
	motor_cmd_t motors;
	logic motor_valid;
	logic busy;

	// reference model state
	logic [WB_DAT_BITS-1:0] model_gain [GAIN_WORDS];
	longint model_prev [NUM_AXES];
	axis_sense_t tick_sense [NUM_AXES];
	logic [MOTOR_BITS-1:0] tick_thrust;
	motor_cmd_t exp_queue [$];
	motor_cmd_t exp_cmd;

	integer seed;
	int error_count;
	int errors_before;
	int tests_passed;
	int tests_failed;
	int valid_count;
	int cycle_count;
	int target;

	flight_rate_ctrl flight_rate_ctrl_i (
		.us_clk(us_clk),
		.resetn(resetn),
		.start(start),
		.sense(sense),
		.thrust(thrust),
		.host_req(host_req),
		.host_rsp(host_rsp),
		.motors(motors),
		.motor_valid(motor_valid),
		.busy(busy)
	);

	always #50 us_clk = ~us_clk;

	always @(posedge us_clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles: motor_valid never arrived", cycle_count);
			$display("*** FAILED ***");
			$finish;
		end
	end

	task automatic check_value(input string what, input longint got, input longint expected);
		if (got != expected) begin
			$display("FAILED at %0t: %s, got %0d expected %0d", $time, what, got, expected);
			error_count++;
		end
	endtask

	// motors sampled mid cycle against one expected entry per pulse
	always @(negedge us_clk) begin
		if (resetn && motor_valid) begin
			valid_count++;
			if (exp_queue.size() == 0) begin
				$display("motor_valid at %0t arrived with no tick pending", $time);
				error_count++;
			end else begin
				exp_cmd = exp_queue.pop_front();
				check_value("motor m0", longint'(motors.m0), longint'(exp_cmd.m0));
				check_value("motor m1", longint'(motors.m1), longint'(exp_cmd.m1));
				check_value("motor m2", longint'(motors.m2), longint'(exp_cmd.m2));
				check_value("motor m3", longint'(motors.m3), longint'(exp_cmd.m3));
			end
		end
	end

	function automatic longint limit(input longint v, input longint lo, input longint hi);
		if (v < lo)
			return lo;
		return (v > hi) ? hi : v;
	endfunction

	// gain multiply, arithmetic right shift, then term saturation
	function automatic longint scaled_term(input longint v, input longint gain, input int sh);
		return limit((v * gain) >>> sh, TERM_MIN, TERM_MAX);
	endfunction

	function automatic longint tick_error(input int a);
		return longint'($signed(tick_sense[a].target_rate))
			- longint'($signed(tick_sense[a].actual_rate));
	endfunction

	function automatic motor_cmd_t expected_motors();
		longint rate [NUM_AXES];
		longint err;
		longint p_val;
		longint i_val;
		longint d_val;
		longint t;
		pid_gain_t g;
		pid_shift_t s;
		motor_cmd_t m;
		for (int a = 0; a < NUM_AXES; a++) begin
			g = pid_gain_t'(model_gain[GAIN_WORDS_PER_AXIS * a]);
			s = pid_shift_t'(model_gain[GAIN_WORDS_PER_AXIS * a + 1]);
			err = tick_error(a);
			p_val = scaled_term(err, $signed(g.kp), s.kp_shift);
			i_val = scaled_term($signed(tick_sense[a].angle_error), $signed(g.ki), s.ki_shift);
			d_val = scaled_term(err - model_prev[a], $signed(g.kd), s.kd_shift);
			rate[a] = limit(p_val + i_val + d_val, RATE_MIN, RATE_MAX);
		end
		// x frame with index 0 roll, 1 pitch and 2 yaw
		t = longint'(tick_thrust);
		m.m0 = MOTOR_BITS'(limit(t + rate[0] + rate[1] - rate[2], 0, MOTOR_MAX));
		m.m1 = MOTOR_BITS'(limit(t - rate[0] + rate[1] + rate[2], 0, MOTOR_MAX));
		m.m2 = MOTOR_BITS'(limit(t - rate[0] - rate[1] - rate[2], 0, MOTOR_MAX));
		m.m3 = MOTOR_BITS'(limit(t + rate[0] - rate[1] + rate[2], 0, MOTOR_MAX));
		return m;
	endfunction

	task automatic host_access(input logic we, input logic [WB_ADR_BITS-1:0] adr,
		input logic [WB_DAT_BITS-1:0] wdat, output logic [WB_DAT_BITS-1:0] rdat);
		@(posedge us_clk);
		#1;
		host_req.cyc = 1'b1;
		host_req.stb = 1'b1;
		host_req.we = we;
		host_req.adr = adr;
		host_req.dat = wdat;
		@(negedge us_clk);
		while (!host_rsp.ack)
			@(negedge us_clk);
		rdat = host_rsp.dat;
		@(posedge us_clk);
		#1;
		host_req = '0;
	endtask

	task automatic host_write(input int adr, input logic [WB_DAT_BITS-1:0] dat);
		logic [WB_DAT_BITS-1:0] unused;
		host_access(1'b1, WB_ADR_BITS'(adr), dat, unused);
	endtask

	task automatic read_and_compare(input int adr, input logic [WB_DAT_BITS-1:0] expected);
		logic [WB_DAT_BITS-1:0] rd;
		host_access(1'b0, WB_ADR_BITS'(adr), '0, rd);
		check_value($sformatf("host read of word %0d", adr), longint'(rd), longint'(expected));
	endtask

	task automatic read_burst(input int n);
		int adr;
		repeat (n) begin
			adr = {$random(seed)} % GAIN_WORDS;
			read_and_compare(adr, model_gain[adr]);
		end
	endtask

	task automatic program_axis(input int a, input int kp, input int ki, input int kd,
		input int kps, input int kis, input int kds);
		pid_gain_t g;
		pid_shift_t s;
		g = '0;
		s = '0;
		g.kp = GAIN_BITS'(kp);
		g.ki = GAIN_BITS'(ki);
		g.kd = GAIN_BITS'(kd);
		s.kp_shift = SHIFT_BITS'(kps);
		s.ki_shift = SHIFT_BITS'(kis);
		s.kd_shift = SHIFT_BITS'(kds);
		model_gain[GAIN_WORDS_PER_AXIS * a] = g;
		model_gain[GAIN_WORDS_PER_AXIS * a + 1] = s;
		host_write(GAIN_WORDS_PER_AXIS * a, g);
		host_write(GAIN_WORDS_PER_AXIS * a + 1, s);
	endtask

	task automatic randomize_sense(input int rate_span, input int angle_span);
		for (int a = 0; a < NUM_AXES; a++) begin
			tick_sense[a].target_rate = RATE_BITS'($random(seed) % rate_span);
			tick_sense[a].actual_rate = RATE_BITS'($random(seed) % rate_span);
			tick_sense[a].angle_error = RATE_BITS'($random(seed) % angle_span);
		end
	endtask

	// full scale, zero or anything in between
	task automatic pick_extreme(output logic signed [RATE_BITS-1:0] v);
		case ({$random(seed)} % 4)
			0: v = -16'sd32768;
			1: v = 16'sd32767;
			2: v = '0;
			default: v = RATE_BITS'($random(seed));
		endcase
	endtask

	task automatic apply_tick_inputs();
		@(posedge us_clk);
		#1;
		for (int a = 0; a < NUM_AXES; a++)
			sense[a] = tick_sense[a];
		thrust = tick_thrust;
		start = 1'b1;
		exp_queue.push_back(expected_motors());
		for (int a = 0; a < NUM_AXES; a++)
			model_prev[a] = tick_error(a);
	endtask

	task automatic run_tick();
		int wanted;
		wanted = valid_count + 1;
		apply_tick_inputs();
		@(posedge us_clk);
		#1;
		start = 1'b0;
		while (valid_count < wanted)
			@(posedge us_clk);
	endtask

	task automatic start_test();
		errors_before = error_count;
	endtask

	task automatic end_test(input string name);
		if (error_count == errors_before) begin
			$display("test %s: ok", name);
			tests_passed++;
		end else begin
			$display("test %s: %0d errors", name, error_count - errors_before);
			tests_failed++;
		end
	endtask

	initial begin
		seed = 32'h8f1d9d40;
		us_clk = 1'b0;
		resetn = 1'b0;
		start = 1'b0;
		thrust = '0;
		tick_thrust = '0;
		host_req = '0;
		for (int a = 0; a < NUM_AXES; a++) begin
			sense[a] = '0;
			tick_sense[a] = '0;
			model_prev[a] = 0;
		end
		for (int w = 0; w < GAIN_WORDS; w++)
			model_gain[w] = '0;
		repeat (3) @(posedge us_clk);
		#1 resetn = 1'b1;

		start_test();
		@(negedge us_clk);
		check_value("busy after reset", longint'(busy), 0);
		check_value("motor_valid after reset", longint'(motor_valid), 0);
		check_value("motors after reset", longint'(motors), 0);
		for (int w = 0; w < GAIN_WORDS; w++)
			read_and_compare(w, '0);
		end_test("reset state");

		// pattern mixes every address bit into the word
		start_test();
		for (int w = 0; w < GAIN_WORDS; w++) begin
			model_gain[w] = 32'ha5c3_0f00 ^ (WB_DAT_BITS'(w) * 32'h9e37_79b1);
			host_write(w, model_gain[w]);
		end
		for (int w = 0; w < GAIN_WORDS; w++)
			read_and_compare(w, model_gain[w]);
		host_write(8'h0a, 32'hdead_beef);
		read_and_compare(8'h0a, '0);
		read_and_compare(2, model_gain[2]);
		end_test("register access");

		start_test();
		program_axis(0, 12, 6, 10, 3, 2, 4);
		program_axis(1, 10, 5, -8, 3, 2, 3);
		program_axis(2, 6, 3, 4, 2, 3, 2);
		for (int n = 0; n < 10; n++) begin
			randomize_sense(600, 300);
			tick_thrust = MOTOR_BITS'(1500 + $random(seed) % 500);
			run_tick();
		end
		end_test("modest gains");

		start_test();
		for (int set = 0; set < 2; set++) begin
			for (int a = 0; a < NUM_AXES; a++) begin
				if (set == 0)
					program_axis(a, 127, 127, 127, 0, 0, 0);
				else
					program_axis(a, -128, -100, 120, 1, 0, 2);
			end
			for (int n = 0; n < 4; n++) begin
				for (int a = 0; a < NUM_AXES; a++) begin
					pick_extreme(tick_sense[a].target_rate);
					pick_extreme(tick_sense[a].actual_rate);
					pick_extreme(tick_sense[a].angle_error);
				end
				tick_thrust = (n == 0) ? 12'd0 : (n == 1) ? 12'd4095
					: (n == 2) ? 12'd2048 : 12'd100;
				run_tick();
			end
		end
		end_test("saturation and clamps");

		// start held three cycles and pulsed again mid tick
		start_test();
		randomize_sense(800, 400);
		tick_thrust = 12'd2200;
		target = valid_count + 1;
		apply_tick_inputs();
		repeat (3) @(posedge us_clk);
		#1 start = 1'b0;
		@(negedge us_clk);
		check_value("busy during tick", longint'(busy), 1);
		@(posedge us_clk);
		#1 start = 1'b1;
		@(posedge us_clk);
		#1 start = 1'b0;
		while (valid_count < target)
			@(posedge us_clk);
		repeat (TICK_CYCLES) @(posedge us_clk);
		@(negedge us_clk);
		check_value("motor_valid pulses", valid_count, target);
		check_value("busy after tick", longint'(busy), 0);
		end_test("start ignored while busy");

		start_test();
		program_axis(0, 20, -7, 15, 4, 3, 3);
		for (int n = 0; n < 3; n++) begin
			randomize_sense(1000, 500);
			tick_thrust = MOTOR_BITS'(2000 + $random(seed) % 800);
			fork
				run_tick();
				read_burst(4);
			join
		end
		end_test("host traffic during tick");

		repeat (2) @(posedge us_clk);
		if (exp_queue.size() != 0) begin
			$display("%0d expected motor updates never arrived", exp_queue.size());
			error_count++;
		end
		$display("tests passed %0d, tests failed %0d, mismatches %0d",
			tests_passed, tests_failed, error_count);
		if (error_count == 0 && tests_failed == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* design/flight_rate_ctrl.sv */
// flight rate control top
`timescale 1ns/1ps

module flight_rate_ctrl import flight_rate_pkg::*; (
	input logic us_clk,
	input logic resetn,
	input logic start,
	input axis_sense_t sense [NUM_AXES],
	input logic [MOTOR_BITS-1:0] thrust,
	input wb_req_t host_req,
	output wb_rsp_t host_rsp,
	output motor_cmd_t motors,
	output logic motor_valid,
	output logic busy
);

	wb_req_t m_req [NUM_MASTERS];
	wb_rsp_t m_rsp [NUM_MASTERS];
	wb_req_t s_req;
	wb_rsp_t s_rsp;
	logic signed [RATE_BITS-1:0] rates [NUM_AXES];
	logic rate_done [NUM_AXES];
	logic mix_taken;
	logic tick_start;

	// start is dropped while a tick is in flight
	assign tick_start = start && !busy;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			busy <= 1'b0;
		else if (tick_start)
			busy <= 1'b1;
		else if (motor_valid)
			busy <= 1'b0;
	end

	for (genvar a = 0; a < NUM_AXES; a++) begin : g_axis
		axis_rate_pid axis_rate_pid_i (
			.us_clk(us_clk),
			.resetn(resetn),
			.start(tick_start),
			.mix_taken(mix_taken),
			.axis(axis_t'(a)),
			.sense(sense[a]),
			.bus_req(m_req[a]),
			.bus_rsp(m_rsp[a]),
			.rate_out(rates[a]),
			.rate_done(rate_done[a])
		);
	end

	// host shares the gain bus as the last master
	assign m_req[HOST_MASTER] = host_req;
	assign host_rsp = m_rsp[HOST_MASTER];

	gain_bus_arbiter gain_bus_arbiter_i (
		.us_clk(us_clk),
		.resetn(resetn),
		.m_req(m_req),
		.m_rsp(m_rsp),
		.s_req(s_req),
		.s_rsp(s_rsp)
	);

	pid_gain_regs pid_gain_regs_i (
		.us_clk(us_clk),
		.resetn(resetn),
		.bus_req(s_req),
		.bus_rsp(s_rsp)
	);

	quad_motor_mixer quad_motor_mixer_i (
		.us_clk(us_clk),
		.resetn(resetn),
		.rates(rates),
		.rate_done(rate_done),
		.thrust(thrust),
		.motors(motors),
		.motor_valid(motor_valid),
		.mix_taken(mix_taken)
	);

endmodule

/* design/quad_motor_mixer.sv */
// x-frame motor mixer
`timescale 1ns/1ps

module quad_motor_mixer import flight_rate_pkg::*; (
	input logic us_clk,
	input logic resetn,
	input logic signed [RATE_BITS-1:0] rates [NUM_AXES],
	input logic rate_done [NUM_AXES],
	input logic [MOTOR_BITS-1:0] thrust,
	output motor_cmd_t motors,
	output logic motor_valid,
	output logic mix_taken
);

	logic all_done;
	logic fire;
	logic mix_pulse;
	motor_cmd_t mix;

	function automatic logic [MOTOR_BITS-1:0] clamp_motor(input int sum);
		if (sum < 0)
			return '0;
		if (sum > MOTOR_MAX)
			return MOTOR_BITS'(MOTOR_MAX);
		return MOTOR_BITS'(sum);
	endfunction

	always_comb begin
		all_done = 1'b1;
		for (int i = 0; i < NUM_AXES; i++)
			all_done = all_done & rate_done[i];
	end

	// axes stay done for one cycle after mix_taken
	assign fire = all_done && !mix_pulse;

	always_comb begin : mix_calc
		int t;
		int r;
		int p;
		int y;
		t = int'(thrust);
		r = int'(rates[ROLL]);
		p = int'(rates[PITCH]);
		y = int'(rates[YAW]);
		mix.m0 = clamp_motor(t + r + p - y);
		mix.m1 = clamp_motor(t - r + p + y);
		mix.m2 = clamp_motor(t - r - p - y);
		mix.m3 = clamp_motor(t + r - p + y);
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			mix_pulse <= 1'b0;
			motors <= '0;
		end else begin
			mix_pulse <= fire;
			if (fire)
				motors <= mix;
		end
	end

	assign motor_valid = mix_pulse;
	assign mix_taken = mix_pulse;

endmodule

/* design/pid_gain_regs.sv */
// pid gain register file
`timescale 1ns/1ps

module pid_gain_regs import flight_rate_pkg::*; (
	input logic us_clk,
	input logic resetn,
	input wb_req_t bus_req,
	output wb_rsp_t bus_rsp
);

	logic [WB_DAT_BITS-1:0] gain_mem [GAIN_WORDS];
	logic [$clog2(GAIN_WORDS)-1:0] word_sel;
	logic ack_q;
	logic [WB_DAT_BITS-1:0] rdata_q;
	logic access;
	logic in_map;

	// one ack per strobe so the cycle after ack is skipped
	assign access = bus_req.cyc && bus_req.stb && !ack_q;
	assign in_map = bus_req.adr < WB_ADR_BITS'(GAIN_WORDS);
	assign word_sel = bus_req.adr[$clog2(GAIN_WORDS)-1:0];

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			ack_q <= 1'b0;
			for (int i = 0; i < GAIN_WORDS; i++)
				gain_mem[i] <= '0;
		end else begin
			ack_q <= access;
			// writes outside the map are dropped
			if (access && bus_req.we && in_map)
				gain_mem[word_sel] <= bus_req.dat;
		end
	end

	always_ff @(posedge us_clk) begin
		if (access) begin
			if (in_map && !bus_req.we)
				rdata_q <= gain_mem[word_sel];
			else
				rdata_q <= '0;
		end
	end

	assign bus_rsp.ack = ack_q;
	assign bus_rsp.dat = rdata_q;

endmodule

/* design/gain_bus_arbiter.sv */
// gain bus round-robin arbiter
`timescale 1ns/1ps

module gain_bus_arbiter import flight_rate_pkg::*; (
	input logic us_clk,
	input logic resetn,
	input wb_req_t m_req [NUM_MASTERS],
	output wb_rsp_t m_rsp [NUM_MASTERS],
	output wb_req_t s_req,
	input wb_rsp_t s_rsp
);

	logic [MASTER_BITS-1:0] owner;
	logic [MASTER_BITS-1:0] next_owner;
	logic owned;
	logic found;
	logic release_bus;

	// nobody holds the bus, or the owner just dropped cyc
	assign release_bus = !owned || !m_req[owner].cyc;

	// search starts one past the last owner
	always_comb begin : pick
		int idx;
		found = 1'b0;
		next_owner = owner;
		for (int k = 1; k <= NUM_MASTERS; k++) begin
			idx = (int'(owner) + k) % NUM_MASTERS;
			if (!found && m_req[idx].cyc) begin
				found = 1'b1;
				next_owner = MASTER_BITS'(idx);
			end
		end
	end

	// host as last owner gives roll first pick after reset
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			owner <= MASTER_BITS'(HOST_MASTER);
			owned <= 1'b0;
		end else if (release_bus) begin
			owned <= found;
			if (found)
				owner <= next_owner;
		end
	end

	always_comb begin
		s_req = owned ? m_req[owner] : '0;
		for (int i = 0; i < NUM_MASTERS; i++) begin
			// only the owner sees ack
			m_rsp[i].ack = owned && (owner == MASTER_BITS'(i)) && s_rsp.ack;
			m_rsp[i].dat = s_rsp.dat;
		end
	end

endmodule

/* design/axis_rate_pid.sv */
// axis rate pid unit
`timescale 1ns/1ps

module axis_rate_pid import flight_rate_pkg::*; (
	input logic us_clk,
	input logic resetn,
	input logic start,
	input logic mix_taken,
	input axis_t axis,
	input axis_sense_t sense,
	output wb_req_t bus_req,
	input wb_rsp_t bus_rsp,
	output logic signed [RATE_BITS-1:0] rate_out,
	output logic rate_done
);

	pid_state_t state;
	pid_state_t next_state;

	// gains fetched at the start of every tick
	pid_gain_t gains;
	pid_shift_t shifts;

	logic fetching;
	logic [WB_ADR_BITS-1:0] gain_adr;

	// working registers at full width
	logic signed [OPS_BITS-1:0] rate_err;
	logic signed [OPS_BITS-1:0] prev_err;
	logic signed [OPS_BITS-1:0] err_change;
	logic signed [OPS_BITS-1:0] p_term;
	logic signed [OPS_BITS-1:0] i_term;
	logic signed [OPS_BITS-1:0] d_term;

	// multiply by gain, arithmetic shift, saturate to term range
	function automatic logic signed [OPS_BITS-1:0] scale_term(
		input logic signed [OPS_BITS-1:0] val,
		input logic signed [GAIN_BITS-1:0] gain,
		input logic [SHIFT_BITS-1:0] shift
	);
		logic signed [OPS_BITS-1:0] scaled;
		scaled = (val * gain) >>> shift;
		if (scaled < TERM_MIN)
			return TERM_MIN;
		if (scaled > TERM_MAX)
			return TERM_MAX;
		return scaled;
	endfunction

	function automatic logic signed [RATE_BITS-1:0] clamp_rate(
		input logic signed [OPS_BITS-1:0] total
	);
		if (total < RATE_MIN)
			return RATE_BITS'(RATE_MIN);
		if (total > RATE_MAX)
			return RATE_BITS'(RATE_MAX);
		return total[RATE_BITS-1:0];
	endfunction

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: if (start) next_state = FETCH_GAINS;
			FETCH_GAINS: if (bus_rsp.ack) next_state = FETCH_SHIFTS;
			FETCH_SHIFTS: if (bus_rsp.ack) next_state = CALC1;
			CALC1: next_state = CALC2;
			CALC2: next_state = CALC3;
			CALC3: next_state = CALC4;
			CALC4: next_state = DONE;
			// hold the result until the mixer has it
			DONE: if (mix_taken) next_state = IDLE;
			default: next_state = IDLE;
		endcase
	end

	// cyc stays up across both reads
	assign fetching = (state == FETCH_GAINS) || (state == FETCH_SHIFTS);
	assign gain_adr = WB_ADR_BITS'(GAIN_WORDS_PER_AXIS * int'(axis));

	always_comb begin
		bus_req.cyc = fetching;
		bus_req.stb = fetching;
		bus_req.we = 1'b0;
		bus_req.adr = (state == FETCH_SHIFTS) ? gain_adr + 1'b1 : gain_adr;
		bus_req.dat = '0;
	end

	always_ff @(posedge us_clk) begin
		if (state == FETCH_GAINS && bus_rsp.ack)
			gains <= pid_gain_t'(bus_rsp.dat);
		if (state == FETCH_SHIFTS && bus_rsp.ack)
			shifts <= pid_shift_t'(bus_rsp.dat);
	end

	// error history and output survive across ticks
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			rate_err <= '0;
			prev_err <= '0;
			rate_out <= '0;
		end else begin
			case (state)
				CALC1: begin
					prev_err <= rate_err;
					rate_err <= $signed(sense.target_rate) - $signed(sense.actual_rate);
				end
				CALC4: begin
					rate_out <= clamp_rate(p_term + i_term + d_term);
				end
				default: begin
					rate_out <= rate_out;
				end
			endcase
		end
	end

	always_ff @(posedge us_clk) begin
		case (state)
			CALC1: begin
				// integral comes straight from the angle loop error
				i_term <= scale_term($signed(sense.angle_error), gains.ki, shifts.ki_shift);
			end
			CALC2: begin
				p_term <= scale_term(rate_err, gains.kp, shifts.kp_shift);
				err_change <= rate_err - prev_err;
			end
			CALC3: begin
				d_term <= scale_term(err_change, gains.kd, shifts.kd_shift);
			end
			default: begin
				d_term <= d_term;
			end
		endcase
	end

	assign rate_done = (state == DONE);

endmodule

/* design/flight_rate_pkg.sv */
// flight rate control definitions
package flight_rate_pkg;

	// data widths
	localparam int RATE_BITS = 16;
	localparam int OPS_BITS = 32;
	localparam int MOTOR_BITS = 12;
	localparam int GAIN_BITS = 8;
	localparam int SHIFT_BITS = 4;
	localparam int WB_ADR_BITS = 8;
	localparam int WB_DAT_BITS = 32;

	// clamp and saturation limits
	localparam int RATE_MIN = -2000;
	localparam int RATE_MAX = 2000;
	localparam int TERM_MIN = -32768;
	localparam int TERM_MAX = 32767;
	localparam int MOTOR_MAX = 4095;

	// bus population with the host in the last slot
	localparam int NUM_AXES = 3;
	localparam int NUM_MASTERS = 4;
	localparam int HOST_MASTER = 3;
	localparam int MASTER_BITS = $clog2(NUM_MASTERS);

	// word 2a holds the gains and word 2a+1 the shifts of axis a
	localparam int GAIN_WORDS_PER_AXIS = 2;
	localparam int GAIN_WORDS = NUM_AXES * GAIN_WORDS_PER_AXIS;

	typedef enum logic [1:0] {ROLL, PITCH, YAW} axis_t;

	typedef enum logic [2:0] {
		IDLE, FETCH_GAINS, FETCH_SHIFTS, CALC1, CALC2, CALC3, CALC4, DONE
	} pid_state_t;

	typedef struct packed {
		logic signed [GAIN_BITS-1:0] kp;
		logic signed [GAIN_BITS-1:0] ki;
		logic signed [GAIN_BITS-1:0] kd;
		logic [7:0] rsvd;
	} pid_gain_t;

	typedef struct packed {
		logic [SHIFT_BITS-1:0] kp_shift;
		logic [SHIFT_BITS-1:0] ki_shift;
		logic [SHIFT_BITS-1:0] kd_shift;
		logic [19:0] rsvd;
	} pid_shift_t;

	typedef struct packed {
		logic signed [RATE_BITS-1:0] target_rate;
		logic signed [RATE_BITS-1:0] actual_rate;
		logic signed [RATE_BITS-1:0] angle_error;
	} axis_sense_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [WB_ADR_BITS-1:0] adr;
		logic [WB_DAT_BITS-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [WB_DAT_BITS-1:0] dat;
	} wb_rsp_t;

	typedef struct packed {
		logic [MOTOR_BITS-1:0] m0;
		logic [MOTOR_BITS-1:0] m1;
		logic [MOTOR_BITS-1:0] m2;
		logic [MOTOR_BITS-1:0] m3;
	} motor_cmd_t;

endpackage
